// File: Bender.yml
package:
  name: avl_subsys

sources:
  - files:
      - verilog/configure_pkg.sv
      - verilog/avl_wait_timer.sv
      - verilog/avl_resp_pipe.sv
      - verilog/avl_ram.sv
      - verilog/avl.sv
      - verilog/avl_subsys.sv
  - target: test
    files:
      - sim/avl_subsys_tb.sv

// File: project.f
verilog/configure_pkg.sv
verilog/avl_wait_timer.sv
verilog/avl_resp_pipe.sv
verilog/avl_ram.sv
verilog/avl.sv
verilog/avl_subsys.sv
sim/avl_subsys_tb.sv

// File: sim/avl_subsys_tb.sv
module avl_subsys_tb import configure::*; ();

  localparam int FIELDS        = 5;
  localparam int MAX_REQS      = 64;
  localparam int TRACE_WORDS   = 1 + FIELDS * MAX_REQS;
  localparam int LATENCY       = WAIT_CYCLES + RESP_LATENCY;
  localparam int READY_TIMEOUT = 20;

  logic     clk;
  logic     rst;
  cpu_req_t req;
  cpu_rsp_t rsp;

  // Word 0 is the request count, then five words per request
  logic [31:0] trace_mem [TRACE_WORDS];
  int          mismatch_count;
  int          failure_count;

  // Response monitor state
  logic pending;
  logic pending_write;
  logic expect_ready;
  int   age;

  avl_subsys i_avl_subsys (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  always #10 clk = ~clk;

  // Ready must come exactly LATENCY cycles after each valid strobe
  always @(negedge clk) begin
    if (!rst) begin
      pending       = 1'b0;
      pending_write = 1'b0;
      age           = 0;
    end else begin
      if (pending) begin
        age = age + 1;
      end
      if (req.valid) begin
        pending       = 1'b1;
        pending_write = |req.wstrb;
        age           = 0;
      end
      expect_ready = pending && (age == LATENCY);
      assert (rsp.ready == expect_ready) else begin
        $display("Mismatch at %0t: rsp.ready expected %b got %b",
                 $time, expect_ready, rsp.ready);
        mismatch_count++;
      end
      // Data stays quiet outside a read response
      if (!expect_ready || pending_write) begin
        assert (rsp.rdata == '0) else begin
          $display("Mismatch at %0t: rsp.rdata expected %h got %h",
                   $time, {DATA_W{1'b0}}, rsp.rdata);
          mismatch_count++;
        end
      end
      if (expect_ready) begin
        pending = 1'b0;
      end
    end
  end

  task automatic send_request(
    input logic [ADDR_W-1:0] addr,
    input logic [DATA_W-1:0] wdata,
    input logic [STRB_W-1:0] strb
  );
    @(posedge clk);
    req.valid <= 1'b1;
    req.addr  <= addr;
    req.wdata <= wdata;
    req.wstrb <= strb;
    @(posedge clk);
    req <= '0;
  endtask

  // Returns in the ready cycle, sampled at the falling edge
  task automatic wait_ready(output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < READY_TIMEOUT) begin
      @(negedge clk);
      if (rsp.ready) begin
        seen = 1'b1;
      end
      n++;
    end
  endtask

  initial begin
    int          n_reqs;
    int          idle;
    logic        seen;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] strb;
    logic [31:0] expected;

    clk            = 1'b0;
    rst            = 1'b0;
    req            = '0;
    mismatch_count = 0;
    failure_count  = 0;
    void'($urandom(32'hfc48));

    $readmemh("sim/avl_trace.txt", trace_mem);
    n_reqs = trace_mem[0];
    assert (!$isunknown(trace_mem[0]) && n_reqs > 0 && n_reqs <= MAX_REQS) else begin
      $display("Error: trace file sim/avl_trace.txt holds no usable request count");
      failure_count++;
      n_reqs = 0;
    end

    repeat (3) @(posedge clk);
    rst <= 1'b1;
    // Quiet period to see ready stay low after reset
    repeat (3) @(posedge clk);

    for (int i = 0; i < n_reqs && failure_count == 0; i++) begin
      op       = trace_mem[1 + i * FIELDS];
      addr     = trace_mem[2 + i * FIELDS];
      wdata    = trace_mem[3 + i * FIELDS];
      strb     = trace_mem[4 + i * FIELDS];
      expected = trace_mem[5 + i * FIELDS];
      idle     = $urandom % 4;
      repeat (idle) @(posedge clk);
      send_request(addr, wdata, strb[STRB_W-1:0]);
      wait_ready(seen);
      assert (seen) else begin
        $display("Error at %0t: request %0d got no ready within %0d cycles",
                 $time, i, READY_TIMEOUT);
        failure_count++;
      end
      if (seen && op == 32'd0) begin
        assert (rsp.rdata == expected) else begin
          $display("Mismatch at %0t: rsp.rdata expected %h got %h",
                   $time, expected, rsp.rdata);
          mismatch_count++;
        end
      end
    end

    // Let any stray response show up
    repeat (LATENCY + 2) @(posedge clk);

    $display("Mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/avl_trace.txt
// op (1 write, 0 read), address, write data, strobe, expected read data
// First word is the number of requests, all values in hex
14
// Full word write and read back
1 00000010 12345678 f 00000000
0 00000010 00000000 0 12345678
// Partial strobes merge into the earlier word
1 00000020 aabbccdd f 00000000
1 00000020 11223344 5 00000000
0 00000020 00000000 0 aa22cc44
1 00000024 deadbeef f 00000000
1 00000024 0000ff00 2 00000000
0 00000024 00000000 0 deadffef
1 00000028 01020304 f 00000000
1 00000028 f0e0d0c0 c 00000000
0 00000028 00000000 0 f0e00304
// Aliasing every 1024 bytes, low address bits ignored
1 00000040 cafef00d f 00000000
0 00000440 00000000 0 cafef00d
0 00000043 00000000 0 cafef00d
1 000007fc 55aa55aa f 00000000
0 00000bfc 00000000 0 55aa55aa
0 000003fe 00000000 0 55aa55aa
1 80000050 0badc0de f 00000000
0 00000050 00000000 0 0badc0de
// First word still intact
0 00000010 00000000 0 12345678

// File: verilog/avl.sv
module avl import configure::*; (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t req,
  output cpu_rsp_t rsp,
  output avl_cmd_t cmd,
  input  avl_rsp_t bus
);

  typedef enum logic [1:0] {
    idle,
    load,
    store
  } state_t;

  state_t   state;
  avl_cmd_t cmd_req;
  avl_cmd_t cmd_q;
  logic     is_read;
  logic     issued;
  logic     resp_hit;

  // Decode of the incoming request
  always_comb begin
    is_read            = ~|req.wstrb;
    cmd_req.address    = req.addr;
    cmd_req.byteenable = is_read ? {STRB_W{1'b1}} : req.wstrb;
    cmd_req.read       = req.valid & is_read;
    cmd_req.write      = req.valid & ~is_read;
    cmd_req.writedata  = req.wdata;
  end

  assign resp_hit = (state == load && bus.readdatavalid) ||
                    (state == store && bus.writeresponsevalid);

  always_comb begin
    cmd = '0;
    rsp = '0;
    case (state)
      idle: begin
        // Command goes out in the valid cycle itself
        cmd = cmd_req;
      end
      load, store: begin
        if (!issued) begin
          cmd = cmd_q;
        end
        if (resp_hit) begin
          rsp.ready = 1'b1;
          // Writes return no data
          if (state == load) begin
            rsp.rdata = bus.readdata;
          end
        end
      end
      default: begin
        cmd = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state  <= idle;
      issued <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req.valid) begin
            state  <= is_read ? load : store;
            issued <= ~bus.waitrequest;
          end
        end
        load, store: begin
          if (resp_hit) begin
            state  <= idle;
            issued <= 1'b0;
          end else if (!issued && !bus.waitrequest) begin
            issued <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Held copy of the command while the slave stalls
  always_ff @(posedge clk) begin
    if (state == idle && req.valid) begin
      cmd_q <= cmd_req;
    end
  end

  // Processor must wait for ready before the next strobe
  assert property (@(posedge clk) disable iff (!rst)
    req.valid |-> state == idle)
    else $error("request strobe while bridge busy");

  // Every response answers the command in flight
  assert property (@(posedge clk) disable iff (!rst)
    (bus.readdatavalid || bus.writeresponsevalid) |-> resp_hit)
    else $error("response without a matching command");

endmodule

// File: verilog/avl_ram.sv
module avl_ram import configure::*; (
  input  logic     clk,
  input  logic     rst,
  input  avl_cmd_t cmd,
  output avl_rsp_t bus
);

  logic [DATA_W-1:0]            mem [RAM_WORDS];
  logic [$clog2(RAM_WORDS)-1:0] idx;
  logic                         busy;
  logic                         waitrequest;
  logic                         rd_accept;
  logic                         wr_accept;
  rd_beat_t                     rd_in;
  rd_beat_t                     rd_out;
  logic                         rd_valid;
  wr_beat_t                     wr_in;
  wr_beat_t                     wr_out;
  logic                         wr_valid;

  // Word index, aliases every RAM_WORDS words
  assign idx = cmd.address[$clog2(RAM_WORDS)+1:2];

  assign busy      = cmd.read | cmd.write;
  assign rd_accept = cmd.read & ~waitrequest;
  assign wr_accept = cmd.write & ~waitrequest;

  avl_wait_timer i_avl_wait_timer (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .waitrequest (waitrequest)
  );

  // Byte-enable write
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (cmd.byteenable[b]) begin
          mem[idx][b*8 +: 8] <= cmd.writedata[b*8 +: 8];
        end
      end
    end
  end

  assign rd_in.data = mem[idx];
  assign wr_in.done = 1'b1;

  avl_resp_pipe #(
    .payload_t (rd_beat_t)
  ) i_rd_pipe (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rd_accept),
    .in_data   (rd_in),
    .out_valid (rd_valid),
    .out_data  (rd_out)
  );

  avl_resp_pipe #(
    .payload_t (wr_beat_t)
  ) i_wr_pipe (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (wr_accept),
    .in_data   (wr_in),
    .out_valid (wr_valid),
    .out_data  (wr_out)
  );

  assign bus.readdata           = rd_out.data;
  assign bus.readdatavalid      = rd_valid;
  assign bus.writeresponsevalid = wr_valid & wr_out.done;
  assign bus.waitrequest        = waitrequest;

  // Master must hold the command through a stall
  assert property (@(posedge clk) disable iff (!rst)
    (busy && waitrequest) |=> $stable(cmd))
    else $error("command changed under waitrequest");

endmodule

// File: verilog/avl_resp_pipe.sv
module avl_resp_pipe import configure::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic [RESP_LATENCY-1:0] valid_q;
  payload_t                data_q [RESP_LATENCY];

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < RESP_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload just follows along
  always_ff @(posedge clk) begin
    data_q[0] <= in_data;
    for (int i = 1; i < RESP_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[RESP_LATENCY-1];
  assign out_data  = data_q[RESP_LATENCY-1];

endmodule

// File: verilog/avl_subsys.sv
module avl_subsys import configure::*; (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t req,
  output cpu_rsp_t rsp
);

  // Avalon link between bridge and slave
  avl_cmd_t cmd;
  avl_rsp_t bus;

  avl i_avl (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp),
    .cmd (cmd),
    .bus (bus)
  );

  avl_ram i_avl_ram (
    .clk (clk),
    .rst (rst),
    .cmd (cmd),
    .bus (bus)
  );

endmodule

// File: verilog/avl_wait_timer.sv
module avl_wait_timer import configure::*; (
  input  logic clk,
  input  logic rst,
  input  logic busy,
  output logic waitrequest
);

  // One spare code so the count can reach WAIT_CYCLES
  logic [$clog2(WAIT_CYCLES + 2)-1:0] count;

  // Stall until the command has been presented WAIT_CYCLES times
  assign waitrequest = busy && (count < WAIT_CYCLES);

  always_ff @(posedge clk) begin
    if (!rst) begin
      count <= '0;
    end else if (busy) begin
      if (waitrequest) begin
        count <= count + 1'b1;
      end else begin
        // Accepted this cycle
        count <= '0;
      end
    end
  end

  // A command may only leave after acceptance, so no count is left over
  assert property (@(posedge clk) disable iff (!rst)
    !busy |-> count == '0)
    else $error("wait counter not cleared between commands");

endmodule

// File: verilog/configure_pkg.sv
package configure;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Slave RAM size in words, indexed by address bits 9:2
  localparam int RAM_WORDS = 256;

  // Slave timing
  localparam int WAIT_CYCLES  = 2;
  localparam int RESP_LATENCY = 2;

  // Processor data port, one-cycle valid strobe
  // All-zero strobe means read
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } cpu_rsp_t;

  // Avalon-MM master to slave
  typedef struct packed {
    logic [ADDR_W-1:0] address;
    logic [STRB_W-1:0] byteenable;
    logic              read;
    logic              write;
    logic [DATA_W-1:0] writedata;
  } avl_cmd_t;

  // Avalon-MM slave to master
  typedef struct packed {
    logic [DATA_W-1:0] readdata;
    logic              readdatavalid;
    logic              writeresponsevalid;
    logic              waitrequest;
  } avl_rsp_t;

  // Payloads carried by the slave response pipes
  typedef struct packed {
    logic [DATA_W-1:0] data;
  } rd_beat_t;

  typedef struct packed {
    logic done;
  } wr_beat_t;

endpackage
